// ==== common/ssio_pkg.sv ====
// Physical DDR lane definitions: pin count, nibble and half-word types, clock phase
package ssio_pkg;

// Data pairs on the board
localparam int lane_width = 5;

// One data half of a symbol
typedef logic [3:0] nibble_t;

// One DDR half-word, control flag on top and nibble below
typedef logic [lane_width-1:0] lane_t;

// Forwarded clock at 90 degrees, center aligned to the data eye
localparam logic use_clk90 = 1'b1;

endpackage

// ==== common/link_pkg.sv ====
// Link layer definitions: symbol codes, frame and buffer sizes, training pattern, arbiter states
package link_pkg;

typedef logic [7:0] byte_t;

// Control flag in bit 8, byte below
typedef logic [8:0] symbol_t;

localparam symbol_t code_idle  = {1'b1, 8'hBC};
localparam symbol_t code_start = {1'b1, 8'hFB};
localparam symbol_t code_end   = {1'b1, 8'hFD};

// Seed for the rotating training bit
localparam byte_t code_train_base = 8'h01;

localparam int frame_len  = 4;
localparam int fifo_depth = 8;
localparam int train_len  = 16;

typedef logic [$clog2(fifo_depth)-1:0]   fifo_ptr_t;
typedef logic [$clog2(fifo_depth+1)-1:0] fifo_cnt_t;
typedef logic [$clog2(frame_len+2)-1:0]  frame_idx_t;
typedef logic [$clog2(train_len)-1:0]    train_idx_t;

typedef enum logic [1:0] {
    st_idle,
    st_train,
    st_frame
} arb_state_t;

// Training symbol n is the seed rotated left by n mod 8, control set
function automatic symbol_t train_symbol(input train_idx_t n);
    logic [2:0] rot;
    rot = n[2:0];
    return {1'b1, byte_t'((code_train_base << rot) | (code_train_base >> (4'd8 - rot)))};
endfunction

endpackage

// ==== ssio_ddr/ssio_ddr_out.sv ====
// Generic source-synchronous DDR output registers with forwarded clock
`resetall
`timescale 1ns/1ns
`default_nettype none

module ssio_ddr_out (
    input  wire logic            clk,
    input  wire logic            clk90,
    input  wire ssio_pkg::lane_t input_d1,
    input  wire ssio_pkg::lane_t input_d2,
    output logic                 output_clk,
    output ssio_pkg::lane_t      output_q
);

import ssio_pkg::*;

lane_t d1_reg;
lane_t d2_reg;
lane_t d2_neg_reg;

// Both halves captured together on the rising edge
always_ff @(posedge clk) begin
    d1_reg <= input_d1;
    d2_reg <= input_d2;
end

// Second half moved to the falling edge so it is stable for the low phase
always_ff @(negedge clk) begin
    d2_neg_reg <= d2_reg;
end

// First half while clk is high, second half while low
always_comb begin
    if (clk) begin
        output_q = d1_reg;
    end else begin
        output_q = d2_neg_reg;
    end
end

if (use_clk90) begin : g_clk90
    // Edges land mid-eye
    assign output_clk = clk90;
end else begin : g_clk0
    // Edges aligned with data transitions
    assign output_clk = clk;
end

endmodule

`resetall

// ==== ssio_ddr/ssio_ddr_out_diff.sv ====
// DDR output stage driving complementary pin pairs for forwarded clock and data
`resetall
`timescale 1ns/1ns
`default_nettype none

module ssio_ddr_out_diff (
    input  wire logic            clk,
    input  wire logic            clk90,
    input  wire ssio_pkg::lane_t input_d1,
    input  wire ssio_pkg::lane_t input_d2,
    output logic                 output_clk_p,
    output logic                 output_clk_n,
    output ssio_pkg::lane_t      output_q_p,
    output ssio_pkg::lane_t      output_q_n
);

import ssio_pkg::*;

logic  output_clk;
lane_t output_q;

ssio_ddr_out ssio_ddr_out_inst (
    .clk        (clk),
    .clk90      (clk90),
    .input_d1   (input_d1),
    .input_d2   (input_d2),
    .output_clk (output_clk),
    .output_q   (output_q)
);

// Generic buffer path, true and inverted leg per pair
assign output_clk_p = output_clk;
assign output_clk_n = ~output_clk;
assign output_q_p   = output_q;
assign output_q_n   = ~output_q;

endmodule

`resetall

// ==== src/frame_tx.sv ====
// Payload framer that buffers bytes and sequences start, data and end symbols onto the lane
`resetall
`timescale 1ns/1ns
`default_nettype none

module frame_tx (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            data_valid,
    input  wire link_pkg::byte_t data_byte,
    input  wire logic            frame_adv,
    output logic                 frame_req,
    output link_pkg::symbol_t    frame_sym,
    output logic                 frame_last,
    output logic                 drop
);

import link_pkg::*;

// Index 0 is the start code, then the data bytes, then the end code
localparam frame_idx_t last_idx = frame_idx_t'(frame_len + 1);

byte_t      buf_mem [fifo_depth];
fifo_ptr_t  wr_ptr;
fifo_ptr_t  rd_ptr;
fifo_cnt_t  fill;
frame_idx_t idx;
logic       push;
logic       pop;

// Full buffer throws the byte away
assign drop = data_valid && (fill == fifo_cnt_t'(fifo_depth));
assign push = data_valid && !drop;
assign pop  = frame_adv && (idx != '0) && (idx != last_idx);

always_ff @(posedge clk) begin
    if (push) begin
        buf_mem[wr_ptr] <= data_byte;
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        fill   <= '0;
    end else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
        endcase
    end
end

// Request only once a whole frame sits in the buffer
always_ff @(posedge clk) begin
    if (rst) begin
        frame_req <= 1'b0;
        idx       <= '0;
    end else if (frame_req) begin
        if (frame_adv) begin
            if (idx == last_idx) begin
                idx       <= '0;
                frame_req <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end else if (fill >= fifo_cnt_t'(frame_len)) begin
        frame_req <= 1'b1;
    end
end

always_comb begin
    if (idx == '0) begin
        frame_sym = code_start;
    end else if (idx == last_idx) begin
        frame_sym = code_end;
    end else begin
        frame_sym = {1'b0, buf_mem[rd_ptr]};
    end
end

assign frame_last = (idx == last_idx);

endmodule

`resetall

// ==== src/train_gen.sv ====
// Training burst generator emitting a fixed run of rotating-bit pattern symbols
`resetall
`timescale 1ns/1ns
`default_nettype none

module train_gen (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          train_start,
    input  wire logic          train_adv,
    output logic               train_req,
    output link_pkg::symbol_t  train_sym,
    output logic               train_last,
    output logic               train_busy
);

import link_pkg::*;

localparam train_idx_t last_idx = train_idx_t'(train_len - 1);

logic       busy;
train_idx_t idx;

always_ff @(posedge clk) begin
    if (rst) begin
        busy <= 1'b0;
        idx  <= '0;
    end else if (!busy) begin
        // Start requests during a burst are ignored
        if (train_start) begin
            busy <= 1'b1;
            idx  <= '0;
        end
    end else if (train_adv) begin
        if (idx == last_idx) begin
            busy <= 1'b0;
            idx  <= '0;
        end else begin
            idx <= idx + 1'b1;
        end
    end
end

assign train_req  = busy;
assign train_busy = busy;
assign train_sym  = train_symbol(idx);
assign train_last = (idx == last_idx);

endmodule

`resetall

// ==== src/link_arbiter.sv ====
// Fixed-priority lane arbiter with grant lock, idle fill and registered symbol output
`resetall
`timescale 1ns/1ns
`default_nettype none

module link_arbiter (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               frame_req,
    input  wire link_pkg::symbol_t  frame_sym,
    input  wire logic               frame_last,
    input  wire logic               train_req,
    input  wire link_pkg::symbol_t  train_sym,
    input  wire logic               train_last,
    output logic                    frame_adv,
    output logic                    train_adv,
    output link_pkg::symbol_t       lane_sym
);

import link_pkg::*;

arb_state_t state;

// Holder of the grant gets its symbol taken every cycle
assign train_adv = (state == st_train);
assign frame_adv = (state == st_frame);

always_ff @(posedge clk) begin
    if (rst) begin
        state    <= st_idle;
        lane_sym <= code_idle;
    end else begin
        case (state)
            st_idle: begin
                lane_sym <= code_idle;
                // Training has priority over a pending frame
                if (train_req) begin
                    state <= st_train;
                end else if (frame_req) begin
                    state <= st_frame;
                end
            end
            st_train: begin
                lane_sym <= train_sym;
                if (train_last) begin
                    state <= st_idle;
                end
            end
            st_frame: begin
                lane_sym <= frame_sym;
                if (frame_last) begin
                    state <= st_idle;
                end
            end
            default: begin
                lane_sym <= code_idle;
                state    <= st_idle;
            end
        endcase
    end
end

endmodule

`resetall

// ==== src/ssio_link_tx.sv ====
// DDR transmit link top: framer and training generator share the lane onto differential pins
`resetall
`timescale 1ns/1ns
`default_nettype none

module ssio_link_tx (
    input  wire logic            clk,
    input  wire logic            clk90,
    input  wire logic            rst,
    input  wire logic            data_valid,
    input  wire link_pkg::byte_t data_byte,
    input  wire logic            train_start,
    output logic                 output_clk_p,
    output logic                 output_clk_n,
    output ssio_pkg::lane_t      output_q_p,
    output ssio_pkg::lane_t      output_q_n,
    output logic                 drop,
    output logic                 train_busy
);

import ssio_pkg::*;
import link_pkg::*;

logic    frame_req;
symbol_t frame_sym;
logic    frame_last;
logic    frame_adv;
logic    train_req;
symbol_t train_sym;
logic    train_last;
logic    train_adv;
symbol_t lane_sym;
nibble_t low_nib;
nibble_t high_nib;
lane_t   lane_d1;
lane_t   lane_d2;

frame_tx frame_tx_inst (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data_byte  (data_byte),
    .frame_adv  (frame_adv),
    .frame_req  (frame_req),
    .frame_sym  (frame_sym),
    .frame_last (frame_last),
    .drop       (drop)
);

train_gen train_gen_inst (
    .clk         (clk),
    .rst         (rst),
    .train_start (train_start),
    .train_adv   (train_adv),
    .train_req   (train_req),
    .train_sym   (train_sym),
    .train_last  (train_last),
    .train_busy  (train_busy)
);

link_arbiter link_arbiter_inst (
    .clk        (clk),
    .rst        (rst),
    .frame_req  (frame_req),
    .frame_sym  (frame_sym),
    .frame_last (frame_last),
    .train_req  (train_req),
    .train_sym  (train_sym),
    .train_last (train_last),
    .frame_adv  (frame_adv),
    .train_adv  (train_adv),
    .lane_sym   (lane_sym)
);

// Control flag goes out in both halves, low nibble first
assign low_nib  = lane_sym[3:0];
assign high_nib = lane_sym[7:4];
assign lane_d1  = {lane_sym[8], low_nib};
assign lane_d2  = {lane_sym[8], high_nib};

ssio_ddr_out_diff ssio_ddr_out_diff_inst (
    .clk          (clk),
    .clk90        (clk90),
    .input_d1     (lane_d1),
    .input_d2     (lane_d2),
    .output_clk_p (output_clk_p),
    .output_clk_n (output_clk_n),
    .output_q_p   (output_q_p),
    .output_q_n   (output_q_n)
);

endmodule

`resetall

// ==== verif/ssio_link_tx_tb.sv ====
// Testbench for the DDR transmit link with table stimulus, DDR capture model and symbol checker
`timescale 1ns/1ns

module ssio_link_tx_tb;

import ssio_pkg::*;
import link_pkg::*;

localparam int act_byte  = 0;
localparam int act_train = 1;
localparam int act_wait  = 2;

localparam int wait_drain = 0;
localparam int wait_start = 1;
localparam int wait_busy  = 2;
localparam int wait_idles = 3;

localparam int wait_limit = 400;

logic  clk;
logic  clk90;
logic  rst;
logic  data_valid;
byte_t data_byte;
logic  train_start;
logic  output_clk_p;
logic  output_clk_n;
lane_t output_q_p;
lane_t output_q_n;
logic  drop;
logic  train_busy;

// Stimulus table with an action, a value and a flag per row
// Flag is the expected drop for a byte and marks a start issued during a burst
int   row_act[$];
int   row_val[$];
logic row_flag[$];

// Expected symbols with a last flag at the end of each frame or burst
symbol_t exp_sym[$];
logic    exp_last[$];
byte_t   pending[$];

int          value_errors;
int          other_errors;
int          timeouts;
int          checked;
int          start_seen;
int          idle_seen;
int          idle_run;
int          drop_count;
int          exp_drops;
logic        capture_on;
logic        in_group;
logic        have_low;
lane_t       low_half;
logic [31:0] lcg_state;

ssio_link_tx DUT (
    .clk          (clk),
    .clk90        (clk90),
    .rst          (rst),
    .data_valid   (data_valid),
    .data_byte    (data_byte),
    .train_start  (train_start),
    .output_clk_p (output_clk_p),
    .output_clk_n (output_clk_n),
    .output_q_p   (output_q_p),
    .output_q_n   (output_q_n),
    .drop         (drop),
    .train_busy   (train_busy)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

// Quarter period behind clk
initial begin
    clk90 = 1'b0;
    #5;
    forever #10 clk90 = ~clk90;
end

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Single bit walking left and wrapping every 8 symbols
function automatic symbol_t train_expected(input int n);
    byte_t pattern;
    pattern = 8'h01 << (n % 8);
    return {1'b1, pattern};
endfunction

function automatic void add_row(input int act, input int value, input logic flag);
    row_act.push_back(act);
    row_val.push_back(value);
    row_flag.push_back(flag);
endfunction

function automatic void expect_frame();
    int n;
    exp_sym.push_back(code_start);
    exp_last.push_back(1'b0);
    for (n = 0; n < frame_len; n++) begin
        exp_sym.push_back({1'b0, pending.pop_front()});
        exp_last.push_back(1'b0);
    end
    exp_sym.push_back(code_end);
    exp_last.push_back(1'b1);
endfunction

function automatic void expect_burst();
    int n;
    for (n = 0; n < train_len; n++) begin
        exp_sym.push_back(train_expected(n));
        exp_last.push_back(n == train_len - 1);
    end
endfunction

task automatic build_table();
    int k;
    // Idle link after reset
    add_row(act_wait, wait_idles, 1'b0);
    // Single frame
    add_row(act_byte, 8'h11, 1'b0);
    add_row(act_byte, 8'h22, 1'b0);
    add_row(act_byte, 8'h33, 1'b0);
    add_row(act_byte, 8'h44, 1'b0);
    add_row(act_wait, wait_drain, 1'b0);
    // Two frames back to back
    add_row(act_byte, 8'h55, 1'b0);
    add_row(act_byte, 8'h66, 1'b0);
    add_row(act_byte, 8'h77, 1'b0);
    add_row(act_byte, 8'h88, 1'b0);
    add_row(act_byte, 8'h99, 1'b0);
    add_row(act_byte, 8'hAA, 1'b0);
    add_row(act_byte, 8'hC3, 1'b0);
    add_row(act_byte, 8'h0F, 1'b0);
    add_row(act_wait, wait_drain, 1'b0);
    // Training burst with a second start while busy
    add_row(act_train, 0, 1'b0);
    add_row(act_train, 0, 1'b1);
    add_row(act_wait, wait_drain, 1'b0);
    // Training requested in the middle of a frame
    add_row(act_byte, 8'h12, 1'b0);
    add_row(act_byte, 8'h34, 1'b0);
    add_row(act_byte, 8'h56, 1'b0);
    add_row(act_byte, 8'h78, 1'b0);
    add_row(act_wait, wait_start, 1'b0);
    add_row(act_train, 0, 1'b0);
    add_row(act_wait, wait_drain, 1'b0);
    // Buffer overflow while the lane is held by training
    add_row(act_train, 0, 1'b0);
    add_row(act_wait, wait_busy, 1'b0);
    for (k = 0; k < 9; k++) begin
        add_row(act_byte, int'(next_rand() & 32'hFF), k == 8);
    end
    add_row(act_wait, wait_drain, 1'b0);
endtask

task automatic pulse_byte(input byte_t value, input logic full);
    @(negedge clk);
    data_valid = 1'b1;
    data_byte  = value;
    #5;
    if (drop !== full) begin
        value_errors++;
        $display("Error: drop expected %h got %h", full, drop);
    end
    if (full) begin
        exp_drops++;
    end else begin
        pending.push_back(value);
        if (pending.size() == frame_len) begin
            expect_frame();
        end
    end
endtask

task automatic pulse_train(input logic while_busy);
    @(negedge clk);
    train_start = 1'b1;
    @(negedge clk);
    train_start = 1'b0;
    if (train_busy !== 1'b1) begin
        value_errors++;
        $display("Error: train_busy expected 1 got %h", train_busy);
    end
    // A start during a burst adds nothing
    if (!while_busy) begin
        expect_burst();
    end
endtask

task automatic wait_for(input int what);
    int   base_starts;
    int   base_idles;
    int   n;
    logic done;
    base_starts = start_seen;
    base_idles  = idle_seen;
    n           = 0;
    done        = 1'b0;
    while (!done && n < wait_limit) begin
        @(negedge clk);
        n++;
        case (what)
            wait_drain: done = (exp_sym.size() == 0);
            wait_start: done = (start_seen > base_starts);
            wait_busy:  done = (train_busy === 1'b1);
            default:    done = (idle_seen >= base_idles + 8);
        endcase
    end
    if (!done) begin
        timeouts++;
        case (what)
            wait_drain: $display("Timeout: %0d expected symbols never left", exp_sym.size());
            wait_start: $display("Timeout: no start code appeared on the pins");
            wait_busy:  $display("Timeout: train_busy never went high");
            default:    $display("Timeout: the link sent no run of idle symbols");
        endcase
    end else if (what == wait_drain && train_busy !== 1'b0) begin
        value_errors++;
        $display("Error: train_busy expected 0 got %h", train_busy);
    end
endtask

task automatic check_pins(input logic clk_level);
    if (output_clk_p !== clk_level) begin
        value_errors++;
        $display("Error: output_clk_p expected %h got %h", clk_level, output_clk_p);
    end
    if (output_clk_n !== ~output_clk_p) begin
        value_errors++;
        $display("Error: output_clk_n expected %h got %h", ~output_clk_p, output_clk_n);
    end
    if (output_q_n !== ~output_q_p) begin
        value_errors++;
        $display("Error: output_q_n expected %h got %h", ~output_q_p, output_q_n);
    end
endtask

task automatic check_symbol(input symbol_t sym);
    if (sym === code_start) begin
        start_seen++;
    end
    if (!in_group && sym === code_idle) begin
        idle_seen++;
        idle_run++;
    end else if (exp_sym.size() == 0) begin
        value_errors++;
        $display("Error: output_q_p expected %03h got %03h", code_idle, sym);
    end else begin
        // Arbiter drops back to idle for a cycle between grants
        if (!in_group && idle_run == 0) begin
            other_errors++;
            $display("No idle symbol between two grants before symbol %03h", sym);
        end
        if (sym !== exp_sym[0]) begin
            value_errors++;
            $display("Error: output_q_p expected %03h got %03h", exp_sym[0], sym);
        end
        checked++;
        in_group = !exp_last[0];
        idle_run = 0;
        void'(exp_sym.pop_front());
        void'(exp_last.pop_front());
    end
endtask

// Low half mid-way through the high phase of clk
always @(posedge clk) begin
    #7;
    if (capture_on) begin
        check_pins(1'b1);
        low_half = output_q_p;
        have_low = 1'b1;
    end
end

// High half mid-way through the low phase completes the symbol
always @(negedge clk) begin
    #7;
    if (capture_on && have_low) begin
        check_pins(1'b0);
        if (output_q_p[4] !== low_half[4]) begin
            value_errors++;
            $display("Error: output_q_p control expected %h got %h", low_half[4], output_q_p[4]);
        end
        check_symbol({low_half[4], output_q_p[3:0], low_half[3:0]});
    end
end

// Counts every drop pulse over the whole run
always @(negedge clk) begin
    #5;
    if (capture_on && drop === 1'b1) begin
        drop_count++;
    end
end

initial begin
    int i;
    rst          = 1'b1;
    data_valid   = 1'b0;
    data_byte    = '0;
    train_start  = 1'b0;
    value_errors = 0;
    other_errors = 0;
    timeouts     = 0;
    checked      = 0;
    start_seen   = 0;
    idle_seen    = 0;
    idle_run     = 1;
    drop_count   = 0;
    exp_drops    = 0;
    capture_on   = 1'b0;
    in_group     = 1'b0;
    have_low     = 1'b0;
    low_half     = '0;
    lcg_state    = 32'hc3a1;
    build_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst        = 1'b0;
    capture_on = 1'b1;
    if (train_busy !== 1'b0 || drop !== 1'b0) begin
        other_errors++;
        $display("train_busy or drop is not low after reset");
    end
    for (i = 0; i < row_act.size(); i++) begin
        case (row_act[i])
            act_byte:  pulse_byte(byte_t'(row_val[i]), row_flag[i]);
            act_train: pulse_train(row_flag[i]);
            default:   wait_for(row_val[i]);
        endcase
        // Strobe ends after the last byte of a run
        if (row_act[i] == act_byte && (i + 1 == row_act.size() || row_act[i + 1] != act_byte)) begin
            @(negedge clk);
            data_valid = 1'b0;
        end
    end
    if (drop_count != exp_drops) begin
        other_errors++;
        $display("drop pulsed %0d times where %0d were expected", drop_count, exp_drops);
    end
    $display("Summary: %0d value errors, %0d other failures, %0d timeouts, %0d symbols matched",
             value_errors, other_errors, timeouts, checked);
    if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
        $display("All checks passed");
    end else begin
        $display("Checks failed");
    end
    $finish;
end

endmodule

// ==== filelist.f ====
common/ssio_pkg.sv
common/link_pkg.sv
ssio_ddr/ssio_ddr_out.sv
ssio_ddr/ssio_ddr_out_diff.sv
src/frame_tx.sv
src/train_gen.sv
src/link_arbiter.sv
src/ssio_link_tx.sv
verif/ssio_link_tx_tb.sv

// ==== Bender.yml ====
package:
  name: ssio_link_tx

sources:
  - files:
      - common/ssio_pkg.sv
      - common/link_pkg.sv
      - ssio_ddr/ssio_ddr_out.sv
      - ssio_ddr/ssio_ddr_out_diff.sv
      - src/frame_tx.sv
      - src/train_gen.sv
      - src/link_arbiter.sv
      - src/ssio_link_tx.sv
  - target: test
    files:
      - verif/ssio_link_tx_tb.sv
